// ==== cpuPkg.sv ====
// shared widths, register count, opcode values and instruction field positions
`default_nettype none

package cpuPkg;

	// datapath sizing
	localparam int dataWidth    = 16;  // one word
	localparam int regCount     = 8;
	localparam int regAddrWidth = 3;   // log2 of regCount
	localparam int opcodeWidth  = 4;
	localparam int immWidth     = 8;   // raw immediate before sign extension
	localparam int shamtWidth   = 4;   // shift amount, low bits of source 2

	// opcodes, top nibble of the instruction
	localparam logic [opcodeWidth-1:0] opAdd = 4'd0;
	localparam logic [opcodeWidth-1:0] opSub = 4'd1;
	localparam logic [opcodeWidth-1:0] opAnd = 4'd2;
	localparam logic [opcodeWidth-1:0] opOr  = 4'd3;
	localparam logic [opcodeWidth-1:0] opXor = 4'd4;
	localparam logic [opcodeWidth-1:0] opSll = 4'd5;
	localparam logic [opcodeWidth-1:0] opSra = 4'd6;  // arithmetic, keeps sign
	localparam logic [opcodeWidth-1:0] opLdi = 4'd7;  // last register-writing opcode
	// 8 to 14 undefined
	localparam logic [opcodeWidth-1:0] opNop = 4'd15;

	// instruction field positions
	localparam int opMsb   = 15;
	localparam int opLsb   = 12;
	localparam int destMsb = 11;
	localparam int destLsb = 9;
	localparam int src1Msb = 8;
	localparam int src1Lsb = 6;
	localparam int src2Msb = 5;
	localparam int src2Lsb = 3;
	// immediate overlaps the source fields, only meaningful for LDI
	localparam int immMsb  = 7;
	localparam int immLsb  = 0;

endpackage

`default_nettype wire

// ==== instrDecode.sv ====
// instruction field split, immediate sign extension and opcode classification
`default_nettype none

module instrDecode
	import cpuPkg::*;
(
	input  wire logic [dataWidth-1:0]    instr,
	output logic      [opcodeWidth-1:0]  opcode,
	output logic      [regAddrWidth-1:0] destReg,
	output logic      [regAddrWidth-1:0] src1Reg,
	output logic      [regAddrWidth-1:0] src2Reg,
	output logic      [dataWidth-1:0]    immValue,
	output logic                         writesReg,  // result goes to register file
	output logic                         illegalOp   // undefined opcode
);

	logic [immWidth-1:0] immRaw;

	// plain field slicing, no state
	assign opcode  = instr[opMsb:opLsb];
	assign destReg = instr[destMsb:destLsb];
	assign src1Reg = instr[src1Msb:src1Lsb];
	assign src2Reg = instr[src2Msb:src2Lsb];

	assign immRaw = instr[immMsb:immLsb];

	// replicate top bit of the byte into the upper half
	assign immValue = {{(dataWidth-immWidth){immRaw[immWidth-1]}}, immRaw};

	// opcodes 0..7 write a destination, 15 is nop, rest undefined
	always_comb begin
		writesReg = 1'b0;
		illegalOp = 1'b0;
		if (opcode <= opLdi) begin
			writesReg = 1'b1;  // alu ops and ldi
		end else if (opcode != opNop) begin
			illegalOp = 1'b1;  // 8 to 14
		end
	end

endmodule

`default_nettype wire

// ==== registerFile.sv ====
// eight-entry register file with two combinational read ports, one write port and write forwarding
`default_nettype none

module registerFile
	import cpuPkg::*;
(
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire logic [regAddrWidth-1:0] src1Reg,      // read port 1 select
	input  wire logic [regAddrWidth-1:0] src2Reg,      // read port 2 select
	input  wire logic                    writeEnable,
	input  wire logic [regAddrWidth-1:0] writeReg,
	input  wire logic [dataWidth-1:0]    writeData,
	output logic      [dataWidth-1:0]    src1Data,
	output logic      [dataWidth-1:0]    src2Data
);

	logic [regCount-1:0]  wrEn;               // one-hot write strobe
	logic [dataWidth-1:0] regOut [regCount];  // current register contents
	logic                 fwd1;
	logic                 fwd2;

	// one register per slot, each with its own decoded enable
	genvar i;
	generate
		for (i = 0; i < regCount; i++) begin : genReg
			logic [dataWidth-1:0] regQ;

			assign wrEn[i] = writeEnable && (writeReg == regAddrWidth'(i));

			always_ff @(posedge clk) begin
				if (reset) begin
					regQ <= '0;           // all registers start at zero
				end else if (wrEn[i]) begin
					regQ <= writeData;
				end
			end

			assign regOut[i] = regQ;
		end
	endgenerate

	// bypass: a write landing this edge is visible to reads in the same cycle
	assign fwd1 = writeEnable && (writeReg == src1Reg);
	assign fwd2 = writeEnable && (writeReg == src2Reg);

	// read ports
	assign src1Data = fwd1 ? writeData : regOut[src1Reg];
	assign src2Data = fwd2 ? writeData : regOut[src2Reg];

endmodule

`default_nettype wire

// ==== aluUnit.sv ====
// combinational ALU for add, subtract, logic, shifts and load-immediate with signed overflow flag
`default_nettype none

module aluUnit
	import cpuPkg::*;
(
	input  wire logic [opcodeWidth-1:0] opcode,
	input  wire logic [dataWidth-1:0]   src1Data,
	input  wire logic [dataWidth-1:0]   src2Data,
	input  wire logic [dataWidth-1:0]   immValue,   // already sign-extended
	output logic      [dataWidth-1:0]   aluResult,
	output logic                        overflow    // signed, add and sub only
);

	logic [dataWidth-1:0]  sumVal;
	logic [dataWidth-1:0]  diffVal;
	logic [shamtWidth-1:0] shamt;
	logic                  sign1;
	logic                  sign2;

	assign sumVal  = src1Data + src2Data;   // wraps
	assign diffVal = src1Data - src2Data;
	assign shamt   = src2Data[shamtWidth-1:0];  // upper bits ignored

	assign sign1 = src1Data[dataWidth-1];
	assign sign2 = src2Data[dataWidth-1];

	always_comb begin
		aluResult = '0;   // nop and undefined give zero
		overflow  = 1'b0;
		case (opcode)
			opAdd: begin
				aluResult = sumVal;
				// same-sign operands, result sign flipped
				overflow = (sign1 == sign2) && (sumVal[dataWidth-1] != sign1);
			end
			opSub: begin
				aluResult = diffVal;
				// opposite signs, result sign differs from minuend
				overflow = (sign1 != sign2) && (diffVal[dataWidth-1] != sign1);
			end
			opAnd: aluResult = src1Data & src2Data;
			opOr:  aluResult = src1Data | src2Data;
			opXor: aluResult = src1Data ^ src2Data;
			opSll: aluResult = src1Data << shamt;
			opSra: begin
				aluResult = $signed(src1Data) >>> shamt;  // sign fill
			end
			opLdi: aluResult = immValue;
			default: begin
				aluResult = '0;
				overflow  = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== resultStage.sv ====
// result pipeline register driving the register-file write port and the fault flag
`default_nettype none

module resultStage
	import cpuPkg::*;
(
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire logic                    instrValid,
	input  wire logic                    writesReg,
	input  wire logic                    illegalOp,
	input  wire logic                    overflow,
	input  wire logic [regAddrWidth-1:0] destReg,
	input  wire logic [dataWidth-1:0]    aluResult,
	output logic                         writeEnable,  // doubles as resultValid
	output logic      [regAddrWidth-1:0] writeReg,
	output logic      [dataWidth-1:0]    writeData,
	output logic                         fault
);

	// flags, one pulse per accepted instruction
	always_ff @(posedge clk) begin
		if (reset) begin
			writeEnable <= 1'b0;
			fault       <= 1'b0;
		end else begin
			writeEnable <= instrValid && writesReg;
			fault       <= instrValid && (overflow || illegalOp);  // overflow still writes
		end
	end

	// payload, only meaningful while writeEnable is high
	always_ff @(posedge clk) begin
		if (instrValid) begin
			writeReg  <= destReg;
			writeData <= aluResult;
		end
	end

endmodule

`default_nettype wire

// ==== execCore.sv ====
// execute core top level with decode, register file, ALU and result stage
`default_nettype none

module execCore
	import cpuPkg::*;
(
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire logic                    instrValid,   // one instruction per high cycle
	input  wire logic [dataWidth-1:0]    instr,
	output logic                         resultValid,
	output logic      [regAddrWidth-1:0] resultReg,
	output logic      [dataWidth-1:0]    result,
	output logic                         fault
);

	logic [opcodeWidth-1:0]  opcode;
	logic [regAddrWidth-1:0] destReg;
	logic [regAddrWidth-1:0] src1Reg;
	logic [regAddrWidth-1:0] src2Reg;
	logic [dataWidth-1:0]    immValue;
	logic                    writesReg;
	logic                    illegalOp;
	logic [dataWidth-1:0]    src1Data;
	logic [dataWidth-1:0]    src2Data;
	logic [dataWidth-1:0]    aluResult;
	logic                    overflow;

	instrDecode decode (
		.instr     (instr),
		.opcode    (opcode),
		.destReg   (destReg),
		.src1Reg   (src1Reg),
		.src2Reg   (src2Reg),
		.immValue  (immValue),
		.writesReg (writesReg),
		.illegalOp (illegalOp)
	);

	// write port fed straight from the result register
	registerFile regs (
		.clk         (clk),
		.reset       (reset),
		.src1Reg     (src1Reg),
		.src2Reg     (src2Reg),
		.writeEnable (resultValid),
		.writeReg    (resultReg),
		.writeData   (result),
		.src1Data    (src1Data),
		.src2Data    (src2Data)
	);

	aluUnit alu (
		.opcode    (opcode),
		.src1Data  (src1Data),
		.src2Data  (src2Data),
		.immValue  (immValue),
		.aluResult (aluResult),
		.overflow  (overflow)
	);

	// one cycle latency stage, outputs shared with top ports
	resultStage stage (
		.clk         (clk),
		.reset       (reset),
		.instrValid  (instrValid),
		.writesReg   (writesReg),
		.illegalOp   (illegalOp),
		.overflow    (overflow),
		.destReg     (destReg),
		.aluResult   (aluResult),
		.writeEnable (resultValid),
		.writeReg    (resultReg),
		.writeData   (result),
		.fault       (fault)
	);

endmodule

`default_nettype wire

// ==== execCore_assertions.sv ====
// bound checker with shadow register file, one-deep result prediction and concurrent assertions
`default_nettype none

module execCore_assertions
	import cpuPkg::*;
(
	input wire logic                    clk,
	input wire logic                    reset,
	input wire logic                    instrValid,
	input wire logic [dataWidth-1:0]    instr,
	input wire logic                    resultValid,
	input wire logic [regAddrWidth-1:0] resultReg,
	input wire logic [dataWidth-1:0]    result,
	input wire logic                    fault
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [dataWidth-1:0]    shadowRegs [regCount];  // architectural state, sequential order
	logic [opcodeWidth-1:0]  op;
	logic [regAddrWidth-1:0] rd;
	logic [dataWidth-1:0]    opA;
	logic [dataWidth-1:0]    opB;
	logic [dataWidth-1:0]    imm;
	logic                    isWriter;
	logic                    isIllegal;
	logic [dataWidth-1:0]    modelValue;
	logic                    modelOverflow;
	logic                    predValid;  // one-deep prediction of the next result
	logic                    predFault;
	logic [regAddrWidth-1:0] predReg;
	logic [dataWidth-1:0]    predData;
	logic                    failReset = 1'b0;
	logic                    failValid = 1'b0;
	logic                    failFault = 1'b0;
	logic                    failReg = 1'b0;
	logic                    failData = 1'b0;
	logic                    failLatency = 1'b0;
	logic                    failIdle = 1'b0;
	logic                    anyFail;  // watched by the testbench top

	assign op  = instr[opMsb:opLsb];
	assign rd  = instr[destMsb:destLsb];
	assign opA = shadowRegs[instr[src1Msb:src1Lsb]];
	assign opB = shadowRegs[instr[src2Msb:src2Lsb]];
	assign imm = {{8{instr[7]}}, instr[7:0]};

	// 0..7 write, 8..14 undefined, 15 nop
	assign isWriter  = (op <= opLdi);
	assign isIllegal = (op >= 4'd8) && (op <= 4'd14);

	// reference arithmetic in 32-bit signed space, overflow when out of 16-bit range
	always_comb begin
		int wide;
		wide          = 0;
		modelValue    = '0;
		modelOverflow = 1'b0;
		case (op)
			opAdd: begin
				wide          = int'($signed(opA)) + int'($signed(opB));
				modelValue    = wide[dataWidth-1:0];  // wrapped sum
				modelOverflow = (wide > 32767) || (wide < -32768);
			end
			opSub: begin
				wide          = int'($signed(opA)) - int'($signed(opB));
				modelValue    = wide[dataWidth-1:0];
				modelOverflow = (wide > 32767) || (wide < -32768);
			end
			opAnd:   modelValue = opA & opB;
			opOr:    modelValue = opA | opB;
			opXor:   modelValue = opA ^ opB;
			opSll:   modelValue = opA << opB[3:0];
			opSra:   modelValue = $signed(opA) >>> opB[3:0];
			opLdi:   modelValue = imm;
			default: modelValue = '0;  // nop and undefined write nothing
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int k = 0; k < regCount; k++) begin
				shadowRegs[k] <= '0;
			end
			predValid <= 1'b0;
			predFault <= 1'b0;
			predReg   <= '0;
			predData  <= '0;
		end else begin
			predValid <= instrValid && isWriter;
			predFault <= instrValid && (modelOverflow || isIllegal);
			predReg   <= rd;
			predData  <= modelValue;
			if (instrValid && isWriter) begin
				shadowRegs[rd] <= modelValue;  // next instruction sees it, like the bypass
			end
		end
	end

	assign anyFail = failReset | failValid | failFault | failReg | failData | failLatency
		| failIdle;

	aReset: assert property (@(posedge clk) reset |=> !resultValid && !fault)
		else begin
			failReset = 1'b1;
			$error("resultValid or fault was high right after a reset cycle");
		end

	aValid: assert property (@(posedge clk) disable iff (reset) resultValid == predValid)
		else begin
			failValid = 1'b1;
			$error("FAIL validCheck expected %0b actual %0b",
				$sampled(predValid), $sampled(resultValid));
		end

	aFault: assert property (@(posedge clk) disable iff (reset) fault == predFault)
		else begin
			failFault = 1'b1;
			$error("FAIL faultCheck expected %0b actual %0b",
				$sampled(predFault), $sampled(fault));
		end

	aResultReg: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> resultReg == predReg)
		else begin
			failReg = 1'b1;
			$error("FAIL destCheck expected r%0d actual r%0d",
				$sampled(predReg), $sampled(resultReg));
		end

	aResultData: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> result == predData)
		else begin
			failData = 1'b1;
			$error("FAIL dataCheck expected %h actual %h", $sampled(predData), $sampled(result));
		end

	// fixed one-cycle latency
	aLatency: assert property (@(posedge clk) disable iff (reset)
		instrValid && isWriter |=> resultValid)
		else begin
			failLatency = 1'b1;
			$error("a register-writing instruction gave no result one cycle later");
		end

	aIdle: assert property (@(posedge clk) disable iff (reset)
		!instrValid |=> !resultValid && !fault)
		else begin
			failIdle = 1'b1;
			$error("a result or fault appeared after a cycle with no instruction");
		end

endmodule

bind execCore execCore_assertions coreChecks (
	.clk         (clk),
	.reset       (reset),
	.instrValid  (instrValid),
	.instr       (instr),
	.resultValid (resultValid),
	.resultReg   (resultReg),
	.result      (result),
	.fault       (fault)
);

`default_nettype wire

// ==== execCore_tb.sv ====
// testbench top with clock, reset, directed and random instruction stimulus, result count, timeout
`default_nettype none

module execCore_tb
	import cpuPkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int randomSlots = 300;
	// 5 reset + about 40 directed + 300 random + drain, with margin
	localparam int maxCycles = 400;

	logic                    clk = 1'b0;
	logic                    reset;
	logic                    instrValid;
	logic [dataWidth-1:0]    instr;
	logic                    resultValid;
	logic [regAddrWidth-1:0] resultReg;
	logic [dataWidth-1:0]    result;
	logic                    fault;

	integer seed = 32'hb2e9_e278;
	int     expectCount = 0;  // register-writing instructions sent
	int     resultCount = 0;  // resultValid pulses seen
	int     cycleCount = 0;

	execCore execCore_inst (
		.clk         (clk),
		.reset       (reset),
		.instrValid  (instrValid),
		.instr       (instr),
		.resultValid (resultValid),
		.resultReg   (resultReg),
		.result      (result),
		.fault       (fault)
	);

	always #5 clk = ~clk;  // 10 ns period

	task automatic stopWithFailure();
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	function automatic logic [dataWidth-1:0] regOp(input logic [opcodeWidth-1:0] op,
		input logic [regAddrWidth-1:0] rd, input logic [regAddrWidth-1:0] rs1,
		input logic [regAddrWidth-1:0] rs2);
		return {op, rd, rs1, rs2, 3'b000};
	endfunction

	function automatic logic [dataWidth-1:0] loadImm(input logic [regAddrWidth-1:0] rd,
		input logic [7:0] value);
		return {opLdi, rd, 1'b0, value};  // bit 8 unused by ldi
	endfunction

	// one accepted instruction, driven on the falling edge
	task automatic issue(input logic [dataWidth-1:0] word);
		@(negedge clk);
		instrValid = 1'b1;
		instr      = word;
		if (word[opMsb:opLsb] <= opLdi) begin
			expectCount++;
		end
	endtask

	// instrValid low, instr left noisy on purpose
	task automatic idleSlot(input logic [dataWidth-1:0] junk);
		@(negedge clk);
		instrValid = 1'b0;
		instr      = junk;
	endtask

	always @(negedge clk) begin
		if (!reset && resultValid) begin
			resultCount++;  // outputs stable mid-cycle
		end
		if (execCore_inst.coreChecks.anyFail) begin
			$display("a concurrent assertion in the bound checker failed");
			stopWithFailure();
		end
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= maxCycles) begin
			$display("timeout: the run did not finish within %0d cycles", maxCycles);
			stopWithFailure();
		end
	end

	initial begin
		logic [31:0]            rnd;
		logic [opcodeWidth-1:0] op;

		reset      = 1'b1;
		instrValid = 1'b0;
		instr      = {opNop, 12'h000};
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		issue(regOp(opXor, 3'd1, 3'd2, 3'd3));  // all zero after reset

		// load every register
		issue(loadImm(3'd0, 8'h12));
		issue(loadImm(3'd1, 8'h7f));
		issue(loadImm(3'd2, 8'h80));  // negative, sign-extends
		issue(loadImm(3'd3, 8'h01));
		issue(loadImm(3'd4, 8'h05));
		issue(loadImm(3'd5, 8'hc3));
		issue(loadImm(3'd6, 8'h40));
		issue(loadImm(3'd7, 8'hff));

		// each alu op once
		issue(regOp(opAdd, 3'd0, 3'd4, 3'd3));
		issue(regOp(opSub, 3'd1, 3'd2, 3'd4));
		issue(regOp(opAnd, 3'd2, 3'd5, 3'd7));
		issue(regOp(opOr,  3'd3, 3'd2, 3'd6));  // r2 from previous cycle
		issue(regOp(opXor, 3'd4, 3'd5, 3'd0));
		issue(regOp(opSll, 3'd5, 3'd6, 3'd3));
		issue(regOp(opSra, 3'd6, 3'd2, 3'd4));

		// dependent chain through the bypass
		issue(loadImm(3'd5, 8'h33));
		issue(regOp(opAdd, 3'd6, 3'd5, 3'd5));
		issue(regOp(opSub, 3'd7, 3'd6, 3'd5));

		// signed overflow on add and sub
		issue(loadImm(3'd1, 8'h7f));
		issue(loadImm(3'd4, 8'h08));
		issue(regOp(opSll, 3'd1, 3'd1, 3'd4));  // 0x7f00
		issue(regOp(opAdd, 3'd3, 3'd1, 3'd1));
		issue(loadImm(3'd2, 8'h80));
		issue(regOp(opSll, 3'd2, 3'd2, 3'd4));  // 0x8000
		issue(loadImm(3'd3, 8'h01));
		issue(regOp(opSub, 3'd5, 3'd2, 3'd3));
		issue(regOp(opAdd, 3'd6, 3'd5, 3'd5));

		// undefined opcodes and nop
		issue(regOp(4'd9, 3'd0, 3'd1, 3'd2));
		issue(regOp(4'd14, 3'd7, 3'd7, 3'd7));
		issue(regOp(opNop, 3'd3, 3'd3, 3'd3));

		// idle cycles, then read back
		idleSlot(regOp(opAdd, 3'd0, 3'd1, 3'd2));
		idleSlot(loadImm(3'd0, 8'haa));
		idleSlot(16'hffff);
		issue(regOp(opOr, 3'd0, 3'd0, 3'd6));

		// random mix, biased towards register writers
		for (int n = 0; n < randomSlots; n++) begin
			rnd = $random(seed);
			if ((rnd[7:0] % 8'd5) == 8'd0) begin
				idleSlot(rnd[31:16]);
			end else begin
				op = rnd[3] ? {1'b0, rnd[2:0]} : rnd[27:24];
				issue({op, rnd[23:12]});
			end
		end

		// drain the last result
		repeat (3) idleSlot(16'h0000);
		@(posedge clk);

		if (resultCount != expectCount) begin
			$display("FAIL resultCount expected %0d actual %0d", expectCount, resultCount);
			stopWithFailure();
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
cpuPkg.sv
instrDecode.sv
registerFile.sv
aluUnit.sv
resultStage.sv
execCore.sv
execCore_assertions.sv
execCore_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
	--top-module execCore_tb -o simExec
out=$(./obj_dir/simExec +verilator+error+limit+100 2>&1) || true
echo "$out"
if echo "$out" | grep -q "STATUS: PASS"; then
	exit 0
else
	exit 1
fi
